// File: logic/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// address bit 31 picks the I/O region over main memory
`define SOC_MMIO_BIT 31

// I/O device field, device 0 is scratch RAM, device 1 is GPIO
`define SOC_DEV_SEL_LSB 24
`define SOC_DEV_SEL_MSB 27

// memory depths as log2 of 32-bit words
`define SOC_MAIN_DEPTH_LOG2 10
`define SOC_SCRATCH_DEPTH_LOG2 8

// stable cycles before a button changes its debounced state
`define SOC_DEBOUNCE_CYCLES 16

// read data of an I/O device that is not mapped
`define SOC_UNMAPPED_DATA 32'hdead_beef

// gpio pin counts
`define SOC_LED_WIDTH 2
`define SOC_BTN_WIDTH 2

`endif

// File: logic/soc_pkg.sv
package soc_pkg;

	// byte address and bus word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// host 0 is the processor port, host 1 the boot loader port
	typedef logic host_id_t;

	// request as it travels from a host into the fabric
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  we;
	} bus_req_t;

	// response, tagged with the host that issued the request
	typedef struct packed {
		data_t    rdata;
		host_id_t host;
	} bus_rsp_t;

	// decoded destination of an access
	typedef enum logic [1:0] {
		TGT_MAIN,
		TGT_SCRATCH,
		TGT_GPIO,
		TGT_NONE
	} target_t;

	// round-robin pointer, names the host that wins the next tie
	typedef enum logic {
		ARB_PREFER0,
		ARB_PREFER1
	} arb_state_t;

endpackage

// File: logic/word_ram.sv
`timescale 1ns/1ps

module word_ram #(
	parameter int DEPTH_LOG2 = 10
) (
	input  logic                  clk_main,
	input  logic                  i_en,
	input  logic                  i_we,
	input  logic [DEPTH_LOG2-1:0] i_index,
	input  soc_pkg::data_t        i_wdata,
	output soc_pkg::data_t        o_rdata
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	soc_pkg::data_t mem [DEPTH];
	soc_pkg::data_t rdata_q;

	// write port, only while the decoder strobes this RAM
	always_ff @(posedge clk_main) begin
		if (i_en && i_we) begin
			mem[i_index] <= i_wdata;
		end
	end

	// registered read
	// gives the second cycle of the fabric latency
	always_ff @(posedge clk_main) begin
		if (i_en) begin
			rdata_q <= mem[i_index];
		end
	end

	assign o_rdata = rdata_q;

endmodule

// File: logic/gpio_port.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module gpio_port (
	input  logic                      clk_main,
	input  logic                      i_rst_n,
	input  logic                      i_en,
	input  logic                      i_we,
	input  logic                      i_offset,
	input  soc_pkg::data_t            i_wdata,
	output soc_pkg::data_t            o_rdata,
	input  logic [`SOC_BTN_WIDTH-1:0] i_btn,
	output logic [`SOC_LED_WIDTH-1:0] o_led
);

	localparam int CNT_W = $clog2(`SOC_DEBOUNCE_CYCLES);

	logic [`SOC_BTN_WIDTH-1:0] btn_meta;
	logic [`SOC_BTN_WIDTH-1:0] btn_sync;
	logic [`SOC_BTN_WIDTH-1:0] btn_state;
	logic [CNT_W-1:0]          stable_cnt [`SOC_BTN_WIDTH];
	logic [`SOC_LED_WIDTH-1:0] led_q;
	soc_pkg::data_t            rdata_q;

	// two flops against metastability
	always_ff @(posedge clk_main or negedge i_rst_n) begin
		if (!i_rst_n) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= i_btn;
			btn_sync <= btn_meta;
		end
	end

	// per-button counter, restarts whenever input matches the state
	always_ff @(posedge clk_main or negedge i_rst_n) begin
		if (!i_rst_n) begin
			btn_state <= '0;
			for (int i = 0; i < `SOC_BTN_WIDTH; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `SOC_BTN_WIDTH; i++) begin
				if (btn_sync[i] == btn_state[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == CNT_W'(`SOC_DEBOUNCE_CYCLES - 1)) begin
					btn_state[i]  <= btn_sync[i];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

	// led register at offset 0
	always_ff @(posedge clk_main or negedge i_rst_n) begin
		if (!i_rst_n) begin
			led_q <= '0;
		end else if (i_en && i_we && !i_offset) begin
			led_q <= i_wdata[`SOC_LED_WIDTH-1:0];
		end
	end

	// read data one cycle late, same as the RAMs
	always_ff @(posedge clk_main) begin
		if (i_en) begin
			rdata_q <= i_offset ? soc_pkg::data_t'(btn_state) : soc_pkg::data_t'(led_q);
		end
	end

	assign o_rdata = rdata_q;
	assign o_led   = led_q;

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
	input  logic               clk_main,
	input  logic               i_rst_n,

	// processor port
	input  logic               i_h0_req_valid,
	input  soc_pkg::bus_req_t  i_h0_req,
	output logic               o_h0_req_ready,

	// boot loader port
	input  logic               i_h1_req_valid,
	input  soc_pkg::bus_req_t  i_h1_req,
	output logic               o_h1_req_ready,

	// granted request towards the decoder
	output logic               o_valid,
	output soc_pkg::bus_req_t  o_req,
	output soc_pkg::host_id_t  o_host,

	// response back from the decoder
	input  logic               i_rsp_valid,
	input  soc_pkg::bus_rsp_t  i_rsp,

	output logic               o_h0_rsp_valid,
	output soc_pkg::data_t     o_h0_rsp_data,
	output logic               o_h1_rsp_valid,
	output soc_pkg::data_t     o_h1_rsp_data
);

	soc_pkg::arb_state_t rr_ptr;
	logic                gnt0;
	logic                gnt1;
	logic                contend;
	logic                valid_q;
	soc_pkg::bus_req_t   req_q;
	soc_pkg::host_id_t   host_q;

	// a host is ready unless the other one wants the bus and holds the pointer
	assign o_h0_req_ready = !i_h1_req_valid || (rr_ptr == soc_pkg::ARB_PREFER0);
	assign o_h1_req_ready = !i_h0_req_valid || (rr_ptr == soc_pkg::ARB_PREFER1);

	assign gnt0    = i_h0_req_valid && o_h0_req_ready;
	assign gnt1    = i_h1_req_valid && o_h1_req_ready;
	assign contend = i_h0_req_valid && i_h1_req_valid;

	// pointer only moves on a tie, to the host that just lost
	always_ff @(posedge clk_main or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rr_ptr <= soc_pkg::ARB_PREFER0;
		end else if (contend) begin
			if (rr_ptr == soc_pkg::ARB_PREFER0) begin
				rr_ptr <= soc_pkg::ARB_PREFER1;
			end else begin
				rr_ptr <= soc_pkg::ARB_PREFER0;
			end
		end
	end

	// first pipeline stage
	always_ff @(posedge clk_main or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= gnt0 || gnt1;
		end
	end

	always_ff @(posedge clk_main) begin
		if (gnt1) begin
			req_q  <= i_h1_req;
			host_q <= 1'b1;
		end else if (gnt0) begin
			req_q  <= i_h0_req;
			host_q <= 1'b0;
		end
	end

	assign o_valid = valid_q;
	assign o_req   = req_q;
	assign o_host  = host_q;

	// response steering by the host tag
	assign o_h0_rsp_valid = i_rsp_valid && (i_rsp.host == 1'b0);
	assign o_h1_rsp_valid = i_rsp_valid && (i_rsp.host == 1'b1);
	assign o_h0_rsp_data  = i_rsp.rdata;
	assign o_h1_rsp_data  = i_rsp.rdata;

endmodule

// File: logic/address_decoder.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module address_decoder (
	input  logic                               clk_main,
	input  logic                               i_rst_n,

	input  logic                               i_valid,
	input  soc_pkg::bus_req_t                  i_req,
	input  soc_pkg::host_id_t                  i_host,

	output logic                               o_main_en,
	output logic                               o_main_we,
	output logic [`SOC_MAIN_DEPTH_LOG2-1:0]    o_main_index,
	output soc_pkg::data_t                     o_main_wdata,

	output logic                               o_scr_en,
	output logic                               o_scr_we,
	output logic [`SOC_SCRATCH_DEPTH_LOG2-1:0] o_scr_index,
	output soc_pkg::data_t                     o_scr_wdata,

	output logic                               o_gpio_en,
	output logic                               o_gpio_we,
	output logic                               o_gpio_offset,
	output soc_pkg::data_t                     o_gpio_wdata,

	input  soc_pkg::data_t                     i_main_rdata,
	input  soc_pkg::data_t                     i_scr_rdata,
	input  soc_pkg::data_t                     i_gpio_rdata,

	output logic                               o_rsp_valid,
	output soc_pkg::bus_rsp_t                  o_rsp
);

	localparam int DEV_W = `SOC_DEV_SEL_MSB - `SOC_DEV_SEL_LSB + 1;
	localparam logic [DEV_W-1:0] DEV_SCRATCH = 0;
	localparam logic [DEV_W-1:0] DEV_GPIO    = 1;

	soc_pkg::target_t  tgt;
	logic [DEV_W-1:0]  dev_sel;
	logic              rsp_valid_q;
	soc_pkg::target_t  tgt_q;
	soc_pkg::host_id_t host_q;
	logic              we_q;
	soc_pkg::data_t    rsp_data;

	assign dev_sel = i_req.addr[`SOC_DEV_SEL_MSB:`SOC_DEV_SEL_LSB];

	// main memory below the MMIO bit, then the device field
	always_comb begin
		if (!i_req.addr[`SOC_MMIO_BIT]) begin
			tgt = soc_pkg::TGT_MAIN;
		end else if (dev_sel == DEV_SCRATCH) begin
			tgt = soc_pkg::TGT_SCRATCH;
		end else if (dev_sel == DEV_GPIO) begin
			tgt = soc_pkg::TGT_GPIO;
		end else begin
			tgt = soc_pkg::TGT_NONE;
		end
	end

	// word index from bit 2 up, aliases modulo depth
	assign o_main_en    = i_valid && (tgt == soc_pkg::TGT_MAIN);
	assign o_main_we    = i_req.we;
	assign o_main_index = i_req.addr[2 +: `SOC_MAIN_DEPTH_LOG2];
	assign o_main_wdata = i_req.wdata;

	assign o_scr_en    = i_valid && (tgt == soc_pkg::TGT_SCRATCH);
	assign o_scr_we    = i_req.we;
	assign o_scr_index = i_req.addr[2 +: `SOC_SCRATCH_DEPTH_LOG2];
	assign o_scr_wdata = i_req.wdata;

	assign o_gpio_en     = i_valid && (tgt == soc_pkg::TGT_GPIO);
	assign o_gpio_we     = i_req.we;
	assign o_gpio_offset = i_req.addr[2];
	assign o_gpio_wdata  = i_req.wdata;

	// second stage, travels with the target read
	always_ff @(posedge clk_main or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= i_valid;
		end
	end

	always_ff @(posedge clk_main) begin
		tgt_q  <= tgt;
		host_q <= i_host;
		we_q   <= i_req.we;
	end

	// writes answer with zero
	always_comb begin
		rsp_data = '0;
		if (!we_q) begin
			case (tgt_q)
				soc_pkg::TGT_MAIN:    rsp_data = i_main_rdata;
				soc_pkg::TGT_SCRATCH: rsp_data = i_scr_rdata;
				soc_pkg::TGT_GPIO:    rsp_data = i_gpio_rdata;
				default:              rsp_data = `SOC_UNMAPPED_DATA;
			endcase
		end
	end

	assign o_rsp_valid = rsp_valid_q;
	assign o_rsp.rdata = rsp_data;
	assign o_rsp.host  = host_q;

endmodule

// File: logic/soc_fabric_top.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_fabric_top (
	input  logic                      clk_main,
	input  logic                      i_rst_n,

	input  logic                      i_h0_req_valid,
	input  soc_pkg::bus_req_t         i_h0_req,
	output logic                      o_h0_req_ready,
	output logic                      o_h0_rsp_valid,
	output soc_pkg::data_t            o_h0_rsp_data,

	input  logic                      i_h1_req_valid,
	input  soc_pkg::bus_req_t         i_h1_req,
	output logic                      o_h1_req_ready,
	output logic                      o_h1_rsp_valid,
	output soc_pkg::data_t            o_h1_rsp_data,

	input  logic [`SOC_BTN_WIDTH-1:0] i_btn,
	output logic [`SOC_LED_WIDTH-1:0] o_led
);

	// arbiter to decoder
	logic              bus_valid;
	soc_pkg::bus_req_t bus_req;
	soc_pkg::host_id_t bus_host;
	logic              rsp_valid;
	soc_pkg::bus_rsp_t rsp;

	// target strobes
	logic                               main_en;
	logic                               main_we;
	logic [`SOC_MAIN_DEPTH_LOG2-1:0]    main_index;
	soc_pkg::data_t                     main_wdata;
	soc_pkg::data_t                     main_rdata;
	logic                               scr_en;
	logic                               scr_we;
	logic [`SOC_SCRATCH_DEPTH_LOG2-1:0] scr_index;
	soc_pkg::data_t                     scr_wdata;
	soc_pkg::data_t                     scr_rdata;
	logic                               gpio_en;
	logic                               gpio_we;
	logic                               gpio_offset;
	soc_pkg::data_t                     gpio_wdata;
	soc_pkg::data_t                     gpio_rdata;

	bus_arbiter bus_arbiter_i (
		.clk_main       (clk_main),
		.i_rst_n        (i_rst_n),
		.i_h0_req_valid (i_h0_req_valid),
		.i_h0_req       (i_h0_req),
		.o_h0_req_ready (o_h0_req_ready),
		.i_h1_req_valid (i_h1_req_valid),
		.i_h1_req       (i_h1_req),
		.o_h1_req_ready (o_h1_req_ready),
		.o_valid        (bus_valid),
		.o_req          (bus_req),
		.o_host         (bus_host),
		.i_rsp_valid    (rsp_valid),
		.i_rsp          (rsp),
		.o_h0_rsp_valid (o_h0_rsp_valid),
		.o_h0_rsp_data  (o_h0_rsp_data),
		.o_h1_rsp_valid (o_h1_rsp_valid),
		.o_h1_rsp_data  (o_h1_rsp_data)
	);

	address_decoder address_decoder_i (
		.clk_main      (clk_main),
		.i_rst_n       (i_rst_n),
		.i_valid       (bus_valid),
		.i_req         (bus_req),
		.i_host        (bus_host),
		.o_main_en     (main_en),
		.o_main_we     (main_we),
		.o_main_index  (main_index),
		.o_main_wdata  (main_wdata),
		.o_scr_en      (scr_en),
		.o_scr_we      (scr_we),
		.o_scr_index   (scr_index),
		.o_scr_wdata   (scr_wdata),
		.o_gpio_en     (gpio_en),
		.o_gpio_we     (gpio_we),
		.o_gpio_offset (gpio_offset),
		.o_gpio_wdata  (gpio_wdata),
		.i_main_rdata  (main_rdata),
		.i_scr_rdata   (scr_rdata),
		.i_gpio_rdata  (gpio_rdata),
		.o_rsp_valid   (rsp_valid),
		.o_rsp         (rsp)
	);

	word_ram #(
		.DEPTH_LOG2 (`SOC_MAIN_DEPTH_LOG2)
	) main_mem_i (
		.clk_main (clk_main),
		.i_en     (main_en),
		.i_we     (main_we),
		.i_index  (main_index),
		.i_wdata  (main_wdata),
		.o_rdata  (main_rdata)
	);

	word_ram #(
		.DEPTH_LOG2 (`SOC_SCRATCH_DEPTH_LOG2)
	) scratch_ram_i (
		.clk_main (clk_main),
		.i_en     (scr_en),
		.i_we     (scr_we),
		.i_index  (scr_index),
		.i_wdata  (scr_wdata),
		.o_rdata  (scr_rdata)
	);

	gpio_port gpio_port_i (
		.clk_main (clk_main),
		.i_rst_n  (i_rst_n),
		.i_en     (gpio_en),
		.i_we     (gpio_we),
		.i_offset (gpio_offset),
		.i_wdata  (gpio_wdata),
		.o_rdata  (gpio_rdata),
		.i_btn    (i_btn),
		.o_led    (o_led)
	);

endmodule

// File: tests/tb_soc_fabric.sv
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_fabric;

	// one table row with its issuing host, access and expected data
	typedef struct packed {
		soc_pkg::host_id_t host;
		soc_pkg::addr_t    addr;
		logic              we;
		soc_pkg::data_t    wdata;
		soc_pkg::data_t    exp;
	} entry_t;

	localparam soc_pkg::addr_t SCR   = 32'h8000_0000;
	localparam soc_pkg::addr_t GPIO  = 32'h8100_0000;
	localparam soc_pkg::addr_t DEV5  = 32'h8500_0000;
	localparam soc_pkg::addr_t ALIAS = 4 * (2 ** `SOC_MAIN_DEPTH_LOG2);

	logic                      clk_main;
	logic                      i_rst_n;
	logic                      i_h0_req_valid;
	soc_pkg::bus_req_t         i_h0_req;
	logic                      o_h0_req_ready;
	logic                      o_h0_rsp_valid;
	soc_pkg::data_t            o_h0_rsp_data;
	logic                      i_h1_req_valid;
	soc_pkg::bus_req_t         i_h1_req;
	logic                      o_h1_req_ready;
	logic                      o_h1_rsp_valid;
	soc_pkg::data_t            o_h1_rsp_data;
	logic [`SOC_BTN_WIDTH-1:0] i_btn;
	logic [`SOC_LED_WIDTH-1:0] o_led;

	entry_t      tbl [$];
	int          sec [8];
	int          pend_idx [$];
	int          pend_cycle [$];
	int          cycle = 0;
	int          cycle_limit = 1000;
	int          checks = 0;
	int          errors = 0;
	logic [31:0] lcg_state = 32'hc9b4;

	soc_fabric_top soc_fabric_top_i (
		.clk_main       (clk_main),
		.i_rst_n        (i_rst_n),
		.i_h0_req_valid (i_h0_req_valid),
		.i_h0_req       (i_h0_req),
		.o_h0_req_ready (o_h0_req_ready),
		.o_h0_rsp_valid (o_h0_rsp_valid),
		.o_h0_rsp_data  (o_h0_rsp_data),
		.i_h1_req_valid (i_h1_req_valid),
		.i_h1_req       (i_h1_req),
		.o_h1_req_ready (o_h1_req_ready),
		.o_h1_rsp_valid (o_h1_rsp_valid),
		.o_h1_rsp_data  (o_h1_rsp_data),
		.i_btn          (i_btn),
		.o_led          (o_led)
	);

	initial begin
		clk_main = 1'b0;
		forever #10 clk_main = ~clk_main;
	end

	always @(posedge clk_main) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("timeout, run stopped after %0d cycles", cycle);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int next_of_host(input int host, input int from, input int last);
		for (int i = from; i < last; i++) begin
			if (tbl[i].host == host) begin
				return i;
			end
		end
		return last;
	endfunction

	task automatic check_value(input string name, input logic [31:0] act,
		input logic [31:0] exp);
		checks++;
		assert (act == exp) else begin
			$display("Error: %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic add_entry(input logic host, input soc_pkg::addr_t addr, input logic we,
		input soc_pkg::data_t wdata, input soc_pkg::data_t exp);
		entry_t e;
		e.host  = host;
		e.addr  = addr;
		e.we    = we;
		e.wdata = wdata;
		e.exp   = exp;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		soc_pkg::data_t w [6];
		for (int i = 0; i < 6; i++) begin
			w[i] = lcg_next();
		end
		// main memory where the alias write lands on index 4 again
		sec[0] = tbl.size();
		add_entry(0, 32'h10, 1, w[0], 0);
		add_entry(0, 32'hffc, 1, w[1], 0);
		add_entry(0, 32'h10 + ALIAS, 1, w[2], 0);
		add_entry(0, 32'h10, 0, 0, w[2]);
		add_entry(0, 32'hffc, 0, 0, w[1]);
		add_entry(0, 32'h10 + ALIAS, 0, 0, w[2]);
		sec[1] = tbl.size();
		add_entry(1, SCR, 1, w[3], 0);
		add_entry(1, SCR + 32'h3fc, 1, w[4], 0);
		add_entry(1, SCR, 0, 0, w[3]);
		add_entry(1, SCR + 32'h3fc, 0, 0, w[4]);
		add_entry(1, DEV5 + 32'h8, 0, 0, `SOC_UNMAPPED_DATA);
		sec[2] = tbl.size();
		// listed in the order the grants must alternate
		add_entry(0, 32'h200, 1, w[5], 0);
		add_entry(1, SCR + 32'h20, 1, w[0], 0);
		add_entry(0, 32'h200, 0, 0, w[5]);
		add_entry(1, SCR + 32'h20, 0, 0, w[0]);
		add_entry(0, 32'hffc, 0, 0, w[1]);
		add_entry(1, DEV5, 0, 0, `SOC_UNMAPPED_DATA);
		sec[3] = tbl.size();
		add_entry(0, GPIO, 1, 32'h2, 0);
		add_entry(0, GPIO, 0, 0, 32'h2);
		add_entry(0, GPIO + 4, 0, 0, 0);
		sec[4] = tbl.size();
		// button 0 pressed and then read during and after a glitch on button 1
		add_entry(0, GPIO + 4, 0, 0, 32'h1);
		sec[5] = tbl.size();
		add_entry(0, GPIO + 4, 0, 0, 32'h1);
		sec[6] = tbl.size();
		add_entry(0, GPIO + 4, 0, 0, 32'h1);
		sec[7] = tbl.size();
	endtask

	task automatic drive_host(input int h, input int idx, input int last);
		soc_pkg::bus_req_t req;
		req = '0;
		if (idx < last) begin
			req.addr  = tbl[idx].addr;
			req.wdata = tbl[idx].wdata;
			req.we    = tbl[idx].we;
		end
		if (h == 0) begin
			i_h0_req_valid = (idx < last);
			i_h0_req       = req;
		end else begin
			i_h1_req_valid = (idx < last);
			i_h1_req       = req;
		end
	endtask

	// both hosts present their next row at once and then wait for all responses
	task automatic run_entries(input int first, input int last);
		int nxt [2];
		int order;
		int taken;
		int acc;
		nxt[0] = next_of_host(0, first, last);
		nxt[1] = next_of_host(1, first, last);
		order = first;
		while (nxt[0] < last || nxt[1] < last) begin
			drive_host(0, nxt[0], last);
			drive_host(1, nxt[1], last);
			@(negedge clk_main);
			acc = cycle;
			taken = -1;
			if (i_h0_req_valid && o_h0_req_ready) begin
				taken = 0;
			end
			if (i_h1_req_valid && o_h1_req_ready) begin
				checks++;
				assert (taken < 0) else begin
					$display("both hosts were granted in cycle %0d", acc);
					errors++;
				end
				taken = 1;
			end
			@(posedge clk_main);
			if (taken >= 0) begin
				checks++;
				assert (nxt[taken] == order) else begin
					$display("host %0d granted row %0d, row %0d was due", taken, nxt[taken],
						order);
					errors++;
				end
				pend_idx.push_back(nxt[taken]);
				pend_cycle.push_back(acc);
				order++;
				nxt[taken] = next_of_host(taken, nxt[taken] + 1, last);
			end
			#2;
		end
		drive_host(0, last, last);
		drive_host(1, last, last);
		while (pend_idx.size() != 0) begin
			@(posedge clk_main);
		end
		#2;
	endtask

	task automatic check_response();
		int             idx;
		int             acc;
		soc_pkg::host_id_t host;
		soc_pkg::data_t data;
		host = o_h1_rsp_valid;
		data = host ? o_h1_rsp_data : o_h0_rsp_data;
		checks += 2;
		assert (!(o_h0_rsp_valid && o_h1_rsp_valid)) else begin
			$display("both hosts got a response in cycle %0d", cycle);
			errors++;
		end
		assert (pend_idx.size() != 0) else begin
			$display("host %0d got a response with no request outstanding", host);
			errors++;
		end
		if (pend_idx.size() != 0) begin
			idx = pend_idx.pop_front();
			acc = pend_cycle.pop_front();
			check_value("o_h0_rsp_valid", o_h0_rsp_valid, tbl[idx].host == 1'b0);
			check_value("o_h1_rsp_valid", o_h1_rsp_valid, tbl[idx].host == 1'b1);
			check_value(host ? "o_h1_rsp_data" : "o_h0_rsp_data", data, tbl[idx].exp);
			checks++;
			assert (cycle - acc == 2) else begin
				$display("row %0d answered %0d cycles after acceptance instead of 2", idx,
					cycle - acc);
				errors++;
			end
		end
	endtask

	// hosts always take their responses
	always @(negedge clk_main) begin
		if (o_h0_rsp_valid || o_h1_rsp_valid) begin
			check_response();
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_main);
		#2;
	endtask

	task automatic report_test(input int num, input string name, input int start);
		if (errors == start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errors - start);
		end
	endtask

	initial begin
		int start;
		int glitch_end;
		i_rst_n        = 1'b0;
		i_h0_req_valid = 1'b0;
		i_h0_req       = '0;
		i_h1_req_valid = 1'b0;
		i_h1_req       = '0;
		i_btn          = '0;
		build_table();
		// four cycles per row for issue and drain plus the reset and debounce waits
		cycle_limit = 4 * tbl.size() + 4 * `SOC_DEBOUNCE_CYCLES + 2;
		repeat (2) @(posedge clk_main);
		#2;
		i_rst_n = 1'b1;

		start = errors;
		@(negedge clk_main);
		check_value("o_h0_req_ready", o_h0_req_ready, 1);
		check_value("o_h1_req_ready", o_h1_req_ready, 1);
		check_value("o_h0_rsp_valid", o_h0_rsp_valid, 0);
		check_value("o_h1_rsp_valid", o_h1_rsp_valid, 0);
		check_value("o_led", o_led, 0);
		@(posedge clk_main);
		#2;
		report_test(1, "reset state", start);

		start = errors;
		run_entries(sec[0], sec[1]);
		report_test(2, "main memory", start);

		start = errors;
		run_entries(sec[1], sec[2]);
		report_test(3, "scratch and unmapped", start);

		start = errors;
		run_entries(sec[2], sec[3]);
		report_test(4, "arbitration", start);

		start = errors;
		run_entries(sec[3], sec[4]);
		check_value("o_led", o_led, 32'h2);
		i_btn = 2'b01;
		wait_cycles(`SOC_DEBOUNCE_CYCLES + 4);
		run_entries(sec[4], sec[5]);
		glitch_end = cycle + `SOC_DEBOUNCE_CYCLES - 5;
		i_btn = 2'b11;
		// read late in the glitch, shortly before its release
		while (cycle < glitch_end - 3) begin
			@(posedge clk_main);
			#2;
		end
		run_entries(sec[5], sec[6]);
		while (cycle < glitch_end) begin
			@(posedge clk_main);
			#2;
		end
		i_btn = 2'b01;
		wait_cycles(2 * `SOC_DEBOUNCE_CYCLES);
		run_entries(sec[6], sec[7]);
		report_test(5, "gpio", start);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+logic
logic/soc_pkg.sv
logic/word_ram.sv
logic/gpio_port.sv
logic/bus_arbiter.sv
logic/address_decoder.sv
logic/soc_fabric_top.sv
tests/tb_soc_fabric.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  - include_dirs:
      - logic
    files:
      - logic/soc_pkg.sv
      - logic/word_ram.sv
      - logic/gpio_port.sv
      - logic/bus_arbiter.sv
      - logic/address_decoder.sv
      - logic/soc_fabric_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_soc_fabric.sv
